// ==== design/basic_cpu_pkg.sv ====
package basic_cpu_pkg;

    localparam int word_w = 16;  // Data word
    localparam int addr_w = 12;  // Memory address

    // Timing phases from the sequence counter
    typedef enum logic [3:0] {
        t0, t1, t2, t3, t4, t5, t6
    } phase_e;

    // Opcode field IR[14:12]
    typedef enum logic [2:0] {
        op_and, op_add, op_lda, op_sta, op_bun, op_bsa, op_isz, op_reg
    } mem_op_e;

    // Register-reference codes, one-hot in the address field
    typedef enum logic [11:0] {
        rr_cla = 12'h800,
        rr_cle = 12'h400,
        rr_cma = 12'h200,
        rr_cme = 12'h100,
        rr_cir = 12'h080,
        rr_cil = 12'h040,
        rr_inc = 12'h020,
        rr_spa = 12'h010,
        rr_sna = 12'h008,
        rr_sza = 12'h004,
        rr_sze = 12'h002,
        rr_mov = 12'h001
    } reg_op_e;

    typedef enum logic [3:0] {
        alu_none, alu_and, alu_add, alu_ld, alu_cla, alu_cle,
        alu_cma, alu_cme, alu_cir, alu_cil, alu_inc
    } alu_op_e;

    typedef enum logic [2:0] {
        sk_none, sk_ac_pos, sk_ac_neg, sk_ac_zero, sk_e_zero, sk_dr_zero
    } skip_e;

    typedef struct packed {
        logic    ar_from_pc;
        logic    ar_from_ir;
        logic    ar_from_mem;
        logic    ar_inc;
        logic    ir_load;
        logic    pc_inc;
        logic    pc_from_ar;
        logic    dr_from_mem;
        logic    dr_inc;
        logic    dr_from_ac;
        logic    i_load;
        logic    mem_we;
        logic    mem_src_pc;  // Write PC with zero top nibble
        logic    mem_src_dr;  // Write DR, else AC
        skip_e   skip_cond;
        alu_op_e alu_op;
        logic    sc_clr;      // Last phase of the instruction
    } ctrl_t;

    typedef struct packed {
        logic [addr_w-1:0] ar;
        logic [addr_w-1:0] pc;
        logic [word_w-1:0] dr;
        logic [word_w-1:0] ac;
        logic [word_w-1:0] ir;
    } cpu_regs_t;

endpackage

// ==== design/sequence_counter.sv ====
module sequence_counter
    import basic_cpu_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   run,
    input  logic   sc_clr,
    output phase_e phase
);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            phase <= t0;
        end else if (!run || sc_clr) begin
            phase <= t0;  // Idle or instruction end
        end else begin
            phase <= phase_e'(phase + 4'd1);
        end
    end

endmodule

// ==== design/control_unit.sv ====
module control_unit
    import basic_cpu_pkg::*;
(
    input  phase_e        phase,
    input  mem_op_e       opcode,
    input  logic          ind,
    input  logic [11:0]   ar,
    input  logic          run,
    output ctrl_t         ctrl
);

    logic is_reg;

    assign is_reg = (opcode == op_reg);  // No I/O, so I is ignored here

    always_comb begin
        ctrl = '0;
        if (run) begin
            case (phase)
                t0: ctrl.ar_from_pc = 1'b1;  // Fetch address
                t1: begin
                    ctrl.ir_load = 1'b1;
                    ctrl.pc_inc  = 1'b1;
                end
                t2: begin
                    ctrl.ar_from_ir = 1'b1;  // Decode, take address field
                    ctrl.i_load     = 1'b1;
                end
                t3: begin
                    if (is_reg) begin
                        ctrl.sc_clr = 1'b1;
                        case (reg_op_e'(ar))
                            rr_cla:  ctrl.alu_op = alu_cla;
                            rr_cle:  ctrl.alu_op = alu_cle;
                            rr_cma:  ctrl.alu_op = alu_cma;
                            rr_cme:  ctrl.alu_op = alu_cme;
                            rr_cir:  ctrl.alu_op = alu_cir;
                            rr_cil:  ctrl.alu_op = alu_cil;
                            rr_inc:  ctrl.alu_op = alu_inc;
                            rr_spa:  ctrl.skip_cond = sk_ac_pos;
                            rr_sna:  ctrl.skip_cond = sk_ac_neg;
                            rr_sza:  ctrl.skip_cond = sk_ac_zero;
                            rr_sze:  ctrl.skip_cond = sk_e_zero;
                            rr_mov:  ctrl.dr_from_ac = 1'b1;
                            default: ;  // Not one-hot, acts as NOP
                        endcase
                    end else if (ind) begin
                        ctrl.ar_from_mem = 1'b1;  // Fetch effective address
                    end
                end
                t4: begin
                    case (opcode)
                        op_and, op_add, op_lda, op_isz: ctrl.dr_from_mem = 1'b1;
                        op_sta: begin
                            ctrl.mem_we = 1'b1;  // Store AC
                            ctrl.sc_clr = 1'b1;
                        end
                        op_bun: begin
                            ctrl.pc_from_ar = 1'b1;
                            ctrl.sc_clr     = 1'b1;
                        end
                        op_bsa: begin
                            ctrl.mem_we     = 1'b1;  // Save return address
                            ctrl.mem_src_pc = 1'b1;
                            ctrl.ar_inc     = 1'b1;
                        end
                        default: ;
                    endcase
                end
                t5: begin
                    case (opcode)
                        op_and: begin
                            ctrl.alu_op = alu_and;
                            ctrl.sc_clr = 1'b1;
                        end
                        op_add: begin
                            ctrl.alu_op = alu_add;
                            ctrl.sc_clr = 1'b1;
                        end
                        op_lda: begin
                            ctrl.alu_op = alu_ld;
                            ctrl.sc_clr = 1'b1;
                        end
                        op_bsa: begin
                            ctrl.pc_from_ar = 1'b1;  // Jump past saved word
                            ctrl.sc_clr     = 1'b1;
                        end
                        op_isz: ctrl.dr_inc = 1'b1;
                        default: ;
                    endcase
                end
                t6: begin
                    if (opcode == op_isz) begin
                        ctrl.mem_we     = 1'b1;
                        ctrl.mem_src_dr = 1'b1;
                        ctrl.skip_cond  = sk_dr_zero;  // Skip when count wraps to zero
                        ctrl.sc_clr     = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== design/alu.sv ====
module alu
    import basic_cpu_pkg::*;
(
    input  alu_op_e     alu_op,
    input  logic [15:0] ac,
    input  logic [15:0] dr,
    input  logic        e,
    output logic [15:0] ac_next,
    output logic        e_next
);

    logic [16:0] sum;

    assign sum = {1'b0, ac} + {1'b0, dr};  // Carry lands in bit 16

    always_comb begin
        ac_next = ac;
        e_next  = e;
        case (alu_op)
            alu_and: ac_next = ac & dr;
            alu_add: begin
                ac_next = sum[15:0];
                e_next  = sum[16];
            end
            alu_ld:  ac_next = dr;
            alu_cla: ac_next = '0;
            alu_cle: e_next = 1'b0;
            alu_cma: ac_next = ~ac;
            alu_cme: e_next = ~e;
            alu_cir: begin
                ac_next = {e, ac[15:1]};  // Rotate right through E
                e_next  = ac[0];
            end
            alu_cil: begin
                ac_next = {ac[14:0], e};
                e_next  = ac[15];
            end
            alu_inc: ac_next = ac + 16'd1;  // E unaffected
            default: ;
        endcase
    end

endmodule

// ==== design/datapath.sv ====
module datapath
    import basic_cpu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  ctrl_t       ctrl,
    input  logic [15:0] mem_rdata,
    input  logic [15:0] ac_next,
    input  logic        e_next,
    output logic [11:0] mem_addr,
    output logic [15:0] mem_wdata,
    output mem_op_e     opcode,
    output logic        ind,
    output logic [15:0] ac,
    output logic [15:0] dr,
    output logic        e,
    output cpu_regs_t   regs
);

    logic [11:0] ar;
    logic [11:0] pc;
    logic [15:0] ir;
    logic        skip_hit;

    always_comb begin
        case (ctrl.skip_cond)
            sk_ac_pos:  skip_hit = ~ac[15];
            sk_ac_neg:  skip_hit = ac[15];
            sk_ac_zero: skip_hit = (ac == '0);
            sk_e_zero:  skip_hit = ~e;
            sk_dr_zero: skip_hit = (dr == '0);
            default:    skip_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ar  <= '0;
            pc  <= '0;
            dr  <= '0;
            ac  <= '0;
            ir  <= '0;
            ind <= 1'b0;
            e   <= 1'b0;
        end else begin
            if (ctrl.ar_from_pc)       ar <= pc;
            else if (ctrl.ar_from_ir)  ar <= ir[11:0];
            else if (ctrl.ar_from_mem) ar <= mem_rdata[11:0];  // Indirect pointer
            else if (ctrl.ar_inc)      ar <= ar + 12'd1;

            if (ctrl.pc_from_ar)                pc <= ar;
            else if (ctrl.pc_inc || skip_hit)   pc <= pc + 12'd1;

            if (ctrl.dr_from_mem)     dr <= mem_rdata;
            else if (ctrl.dr_inc)     dr <= dr + 16'd1;
            else if (ctrl.dr_from_ac) dr <= ac;  // MOV

            if (ctrl.ir_load) ir  <= mem_rdata;
            if (ctrl.i_load)  ind <= ir[15];

            if (ctrl.alu_op != alu_none) begin
                ac <= ac_next;
                e  <= e_next;
            end
        end
    end

    assign mem_addr  = ar;
    assign mem_wdata = ctrl.mem_src_pc ? {4'h0, pc} :
                       ctrl.mem_src_dr ? dr : ac;
    assign opcode    = mem_op_e'(ir[14:12]);
    assign regs      = '{ar: ar, pc: pc, dr: dr, ac: ac, ir: ir};

endmodule

// ==== design/sync_sram.sv ====
module sync_sram
    import basic_cpu_pkg::*;
(
    input  logic        clk,
    input  logic [11:0] addr,
    input  logic        we,
    input  logic [15:0] wdata,
    input  logic        load_we,
    input  logic [11:0] load_addr,
    input  logic [15:0] load_data,
    output logic [15:0] rdata
);

    logic [word_w-1:0] mem [0:(1 << addr_w)-1];  // No reset, contents kept

    assign rdata = mem[addr];  // Asynchronous read

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        if (load_we) begin
            mem[load_addr] <= load_data;  // Program load while idle
        end
    end

endmodule

// ==== design/basic_cpu.sv ====
module basic_cpu
    import basic_cpu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        run,
    input  logic        load_we,
    input  logic [11:0] load_addr,
    input  logic [15:0] load_data,
    output logic        e,
    output cpu_regs_t   regs
);

    phase_e      phase;
    ctrl_t       ctrl;
    mem_op_e     opcode;
    logic        ind;
    logic [15:0] ac;
    logic [15:0] dr;
    logic [15:0] ac_next;
    logic        e_next;
    logic [11:0] mem_addr;
    logic [15:0] mem_wdata;
    logic [15:0] mem_rdata;

    sequence_counter u_sc (
        .clk    (clk),
        .reset  (reset),
        .run    (run),
        .sc_clr (ctrl.sc_clr),
        .phase  (phase)
    );

    control_unit u_ctrl (
        .phase  (phase),
        .opcode (opcode),
        .ind    (ind),
        .ar     (regs.ar),
        .run    (run),
        .ctrl   (ctrl)
    );

    datapath u_dp (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .ac_next   (ac_next),
        .e_next    (e_next),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .opcode    (opcode),
        .ind       (ind),
        .ac        (ac),
        .dr        (dr),
        .e         (e),
        .regs      (regs)
    );

    alu u_alu (
        .alu_op  (ctrl.alu_op),
        .ac      (ac),
        .dr      (dr),
        .e       (e),
        .ac_next (ac_next),
        .e_next  (e_next)
    );

    sync_sram u_mem (
        .clk       (clk),
        .addr      (mem_addr),
        .we        (ctrl.mem_we),
        .wdata     (mem_wdata),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .rdata     (mem_rdata)
    );

endmodule

// ==== sim/basic_cpu_assertions.sv ====
module basic_cpu_assertions
    import basic_cpu_pkg::*;
(
    input logic   clk,
    input logic   reset,
    input logic   run,
    input logic   load_we,
    input phase_e phase,
    input logic   sc_clr,
    input logic   mem_we
);
    timeunit 1ns;
    timeprecision 100ps;

    phase_in_range: assert property (@(posedge clk) disable iff (!reset) phase <= t6)
        else $error("phase counter beyond t6");

    phase_clears: assert property (@(posedge clk) disable iff (!reset) sc_clr |=> phase == t0)
        else $error("phase did not return to t0 after sc_clr");

    load_only_idle: assert property (@(posedge clk) disable iff (!reset) !(load_we && run))
        else $error("program load while the CPU runs");

    no_write_after_reset: assert property (@(posedge clk) $rose(reset) |-> !mem_we)
        else $error("memory write right after reset");

endmodule

bind basic_cpu basic_cpu_assertions u_assertions (
    .clk     (clk),
    .reset   (reset),
    .run     (run),
    .load_we (load_we),
    .phase   (phase),
    .sc_clr  (ctrl.sc_clr),
    .mem_we  (ctrl.mem_we)
);

// ==== sim/basic_cpu_tb.sv ====
module basic_cpu_tb
    import basic_cpu_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        reset;
    logic        run;
    logic        load_we;
    logic [11:0] load_addr;
    logic [15:0] load_data;
    logic        e;
    cpu_regs_t   regs;
    logic [31:0] rng_state;
    logic [11:0] prog_addr [$];
    logic [15:0] prog_data [$];
    int          errors;
    int          tests_run;
    int          tests_failed;

    basic_cpu uut (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .e         (e),
        .regs      (regs)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    function automatic logic [15:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state[15:0];
    endfunction

    task automatic put_word(input logic [11:0] addr, input logic [15:0] data);
        prog_addr.push_back(addr);
        prog_data.push_back(data);
    endtask

    task automatic compare(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h, got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #5;
        reset = 1'b0;
        repeat (10) @(posedge clk);
        #5;
        reset = 1'b1;
    endtask

    // Appends the halt loop, loads the program while idle, runs until the halt loop
    task automatic run_program(input logic [11:0] halt_addr);
        logic [15:0] halt_word;
        int          cycles;
        bit          done;
        halt_word = 16'h4000 | 16'(halt_addr);  // BUN to itself
        put_word(halt_addr, halt_word);
        apply_reset();
        while (prog_addr.size() > 0) begin
            @(posedge clk);
            #5;
            load_we   = 1'b1;
            load_addr = prog_addr.pop_front();
            load_data = prog_data.pop_front();
        end
        @(posedge clk);
        #5;
        load_we = 1'b0;
        @(posedge clk);
        #5;
        run    = 1'b1;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < 2000) begin
            @(posedge clk);
            #5;
            cycles++;
            done = (regs.pc == halt_addr) && (regs.ir == halt_word);
        end
        run = 1'b0;  // Freezes the registers for checking
        if (!done) begin
            $display("Program never reached its halt loop at %h within 2000 cycles", halt_addr);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d error(s)", name, errors - start_errors);
        end
    endtask

    task automatic check_reset();
        int start;
        start = errors;
        apply_reset();
        compare("regs.ar", 16'h0, 16'(regs.ar));
        compare("regs.pc", 16'h0, 16'(regs.pc));
        compare("regs.dr", 16'h0, regs.dr);
        compare("regs.ac", 16'h0, regs.ac);
        compare("regs.ir", 16'h0, regs.ir);
        compare("e", 16'h0, 16'(e));
        finish_test("reset", start);
    endtask

    task automatic check_mem_arith();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        logic [15:0] sum;
        logic        carry;
        int          start;
        start = errors;
        a     = next_random();
        b     = next_random();
        c     = next_random();
        sum   = a + b;
        carry = (sum < a);  // Wrapped past FFFF
        put_word(12'h000, 16'h2100);  // LDA 100
        put_word(12'h001, 16'h1101);  // ADD 101
        put_word(12'h002, 16'h0102);  // AND 102
        put_word(12'h100, a);
        put_word(12'h101, b);
        put_word(12'h102, c);
        run_program(12'h003);
        compare("regs.ac", sum & c, regs.ac);
        compare("e", 16'(carry), 16'(e));  // AND leaves the carry alone
        finish_test("lda_add_and", start);
    endtask

    task automatic check_store_mov();
        logic [15:0] a;
        int          start;
        start = errors;
        a     = next_random();
        put_word(12'h000, 16'h2100);  // LDA 100
        put_word(12'h001, 16'h3101);  // STA 101
        put_word(12'h002, 16'h7800);  // CLA
        put_word(12'h003, 16'h2101);  // LDA 101
        put_word(12'h004, 16'h7200);  // CMA, so DR differs from the loaded word
        put_word(12'h005, 16'h7001);  // MOV
        put_word(12'h100, a);
        run_program(12'h006);
        compare("regs.ac", ~a, regs.ac);
        compare("regs.dr", ~a, regs.dr);
        finish_test("sta_lda_mov", start);
    endtask

    task automatic check_reg_ops();
        logic [15:0] a;
        logic [15:0] ac_m;
        logic        e_m;
        logic        bit_out;
        int          start;
        start = errors;
        a     = next_random();
        put_word(12'h000, 16'h2100);  // LDA 100
        put_word(12'h001, 16'h7100);  // CME
        put_word(12'h002, 16'h7080);  // CIR
        put_word(12'h003, 16'h7200);  // CMA
        put_word(12'h004, 16'h7040);  // CIL
        put_word(12'h005, 16'h7040);  // CIL
        put_word(12'h006, 16'h7020);  // INC
        put_word(12'h100, a);
        run_program(12'h007);
        e_m     = 1'b1;               // E cleared by reset, then CME
        bit_out = a[0];
        ac_m    = {e_m, a[15:1]};
        e_m     = bit_out;
        ac_m    = ~ac_m;
        repeat (2) begin
            bit_out = ac_m[15];
            ac_m    = {ac_m[14:0], e_m};
            e_m     = bit_out;
        end
        ac_m = ac_m + 16'd1;
        compare("regs.ac", ac_m, regs.ac);
        compare("e", 16'(e_m), 16'(e));
        put_word(12'h000, 16'h2100);  // LDA 100
        put_word(12'h001, 16'h7100);  // CME
        put_word(12'h002, 16'h7400);  // CLE
        put_word(12'h003, 16'h7100);  // CME
        put_word(12'h004, 16'h7800);  // CLA
        put_word(12'h005, 16'h7020);  // INC
        put_word(12'h100, a);
        run_program(12'h006);
        compare("regs.ac", 16'h0001, regs.ac);
        compare("e", 16'h0001, 16'(e));
        finish_test("register_ops", start);
    endtask

    // Skip candidate at 2, INC in the slot it may skip
    task automatic skip_case(input logic [15:0] ac_val, input logic [15:0] pre_op,
                             input logic [15:0] skip_op, input logic [15:0] count_val,
                             input bit expect_skip);
        put_word(12'h000, 16'h2100);  // LDA 100
        put_word(12'h001, pre_op);
        put_word(12'h002, skip_op);
        put_word(12'h003, 16'h7020);  // INC
        put_word(12'h100, ac_val);
        put_word(12'h101, count_val);
        run_program(12'h004);
        compare("regs.ac", expect_skip ? ac_val : ac_val + 16'd1, regs.ac);
    endtask

    task automatic check_skips();
        int start;
        start = errors;
        skip_case(16'h1234, 16'h7400, 16'h7010, 16'h0000, 1'b1);  // SPA
        skip_case(16'h8001, 16'h7400, 16'h7010, 16'h0000, 1'b0);
        skip_case(16'h8001, 16'h7400, 16'h7008, 16'h0000, 1'b1);  // SNA
        skip_case(16'h1234, 16'h7400, 16'h7008, 16'h0000, 1'b0);
        skip_case(16'h0000, 16'h7400, 16'h7004, 16'h0000, 1'b1);  // SZA
        skip_case(16'h0005, 16'h7400, 16'h7004, 16'h0000, 1'b0);
        skip_case(16'h0042, 16'h7400, 16'h7002, 16'h0000, 1'b1);  // SZE
        skip_case(16'h0042, 16'h7100, 16'h7002, 16'h0000, 1'b0);
        skip_case(16'h0042, 16'h7400, 16'h6101, 16'hffff, 1'b1);  // ISZ wraps to zero
        skip_case(16'h0042, 16'h7400, 16'h6101, 16'h0005, 1'b0);
        finish_test("skips", start);
    endtask

    task automatic check_branch();
        logic [15:0] v;
        int          start;
        start = errors;
        v     = next_random();
        put_word(12'h000, 16'h5200);  // BSA 200
        put_word(12'h001, 16'h7020);  // INC after return
        put_word(12'h200, 16'h0000);  // Return address slot
        put_word(12'h201, 16'ha300);  // LDA I 300
        put_word(12'h202, 16'hc200);  // BUN I 200
        put_word(12'h300, 16'h0310);
        put_word(12'h310, v);
        run_program(12'h002);
        compare("regs.ac", v + 16'd1, regs.ac);
        compare("regs.dr", v, regs.dr);
        finish_test("bsa_indirect", start);
    endtask

    initial begin
        reset        = 1'b0;
        run          = 1'b0;
        load_we      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        rng_state    = 32'hc9e1_c3bf;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        check_reset();
        check_mem_arith();
        check_store_mov();
        check_reg_ops();
        check_skips();
        check_branch();
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== basic_cpu.f ====
design/basic_cpu_pkg.sv
design/sequence_counter.sv
design/control_unit.sv
design/alu.sv
design/datapath.sv
design/sync_sram.sv
design/basic_cpu.sv
sim/basic_cpu_assertions.sv
sim/basic_cpu_tb.sv
